//--- Makefile
# Verilator lint, simulation and clean for the zmips pipeline

VERILATOR ?= verilator
TOP       ?= tb_zmips
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir

RTL_SRCS = zmips_pkg.sv zmips_if.sv zmips_alu.sv zmips_regfile.sv zmips_fetch.sv \
           zmips_decode.sv zmips_execute.sv zmips_mem_wb.sv zmips_hazard.sv zmips.sv

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --top-module zmips $(RTL_SRCS)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- list.f
zmips_pkg.sv
zmips_if.sv
zmips_alu.sv
zmips_regfile.sv
zmips_fetch.sv
zmips_decode.sv
zmips_execute.sv
zmips_mem_wb.sv
zmips_hazard.sv
zmips.sv
zmips_checker.sv
tb_zmips.sv

//--- tb_zmips.sv
// Testbench for zmips with instruction ROM, data RAM, reference model, store monitor, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_zmips;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] i_addr;
    logic [31:0] i_data;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic [31:0] d_rdata;
    logic        d_wr;
    logic        d_rd;

    logic [31:0] rom [256];     // Program words
    logic [31:0] dmem [64];     // Data RAM over byte addresses 0..255
    int          prog_len = 0;
    bit          built = 1'b0;
    logic [31:0] exp_addr [$];  // Expected stores in program order
    logic [31:0] exp_data [$];
    string       exp_name [$];

    zmips uut (
        .clk     (clk),
        .rst     (rst),
        .i_addr  (i_addr),
        .i_data  (i_data),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .d_wr    (d_wr),
        .d_rd    (d_rd)
    );

    bind zmips zmips_checker chk0 (
        .clk    (clk),
        .rst    (rst),
        .i_addr (i_addr),
        .d_wr   (d_wr),
        .d_rd   (d_rd)
    );

    always #10 clk = ~clk;

    // Instruction ROM reads zero beyond the program
    assign i_data  = (i_addr[31:2] < 30'(prog_len)) ? rom[i_addr[9:2]] : '0;
    assign d_rdata = d_rd ? dmem[d_addr[7:2]] : '0;   // Read data only while d_rd is high

    always @(posedge clk)
    begin
        if (d_wr)
        begin
            dmem[d_addr[7:2]] <= d_wdata;
        end
    end

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;  // Spreads every address bit
    endfunction

    // R-format word with the reserved funct bits at zero
    function automatic logic [31:0] alu_word(input logic [3:0] code, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [4:0] shamt);
        return {5'b00010, code[3], rs, rt, rd, shamt, code[2:0], 3'b000};
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    // Constant into rd through register 0
    task automatic set_reg(input logic [4:0] rd, input logic [25:0] imm);
        emit({6'b010101, imm});
        emit(alu_word(zmips_pkg::alu_pass, 5'd0, 5'd0, rd, 5'd0));
    endtask

    task automatic load_from(input logic [4:0] base, input logic [4:0] rd);
        emit({6'b001100, base, 5'd0, rd, 5'd0, 6'd0});   // Address is rs
    endtask

    task automatic store_to(input logic [4:0] base, input logic [4:0] src, input string name);
        emit({6'b001000, base, src, 5'd0, 5'd0, 6'd0});
        exp_name.push_back(name);
    endtask

    task automatic op_store(input logic [3:0] code, input logic [4:0] rs, input logic [4:0] rt,
                            input logic [4:0] rd, input logic [4:0] shamt, input string name);
        emit(alu_word(code, rs, rt, rd, shamt));
        store_to(5'd1, rd, name);   // Result stored at once
    endtask

    // Runs the program in order and lists every store it makes
    function automatic void run_model();
        logic [31:0] regs [32];
        logic [31:0] mem [64];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] y;
        for (int i = 0; i < 64; i++)
            mem[i] = fill_word(32'(i) << 2);
        for (int pc = 0; pc < prog_len; pc++)
        begin
            w = rom[pc];
            if (w[31:30] == 2'b01)
                regs[0] = {{6{w[25]}}, w[25:0]};    // Load immediate
            else if (w[31:30] == 2'b00)
            begin
                a = regs[w[25:21]];
                b = regs[w[20:16]];
                case ({w[26], w[5:3]})
                    zmips_pkg::alu_add: y = a + b;
                    zmips_pkg::alu_sub: y = a - b;
                    zmips_pkg::alu_and: y = a & b;
                    zmips_pkg::alu_or:  y = a | b;
                    zmips_pkg::alu_xor: y = a ^ b;
                    zmips_pkg::alu_sll: y = a << w[10:6];
                    zmips_pkg::alu_srl: y = a >> w[10:6];
                    // Sign bits fill the vacated top
                    zmips_pkg::alu_sra: y = (a >> w[10:6]) |
                                            ({32{a[31]}} & ~(32'hffff_ffff >> w[10:6]));
                    default:            y = a;
                endcase
                if (w[29] && w[28])
                    regs[w[15:11]] = mem[y[7:2]];
                else if (w[29])
                begin
                    exp_addr.push_back(y);
                    exp_data.push_back(b);
                    mem[y[7:2]] = b;
                end
                else if (w[28])
                    regs[w[15:11]] = y;
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Stores compared in program order at the falling edge
    always @(negedge clk)
    begin
        if (rst && (d_wr === 1'b1 || d_rd === 1'b1))
        begin
            $display("Data memory accessed while reset is high");
            $display("Simulation finished: FAIL");
            $fatal(1, "access in reset");
        end
        else if (!rst && d_wr === 1'b1 && exp_addr.size() == 0)
        begin
            $display("Unexpected store to %h after the last expected store", d_addr);
            $display("Simulation finished: FAIL");
            $fatal(1, "extra store");
        end
        else if (!rst && d_wr === 1'b1)
        begin
            check_value($sformatf("%s addr", exp_name[0]), exp_addr.pop_front(), d_addr);
            check_value($sformatf("%s data", exp_name.pop_front()), exp_data.pop_front(),
                        d_wdata);
        end
    end

    initial
    begin
        wait (built == 1'b1);
        #((prog_len * 2 + 40) * 20);
        $display("Timeout with %0d expected stores still missing", exp_addr.size());
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [31:0] rnd;
        logic [31:0] sh;
        logic [25:0] addr_a;
        logic [25:0] addr_b;
        logic [4:0]  xa;
        logic [4:0]  xb;
        logic [4:0]  xc;
        logic [4:0]  xd;
        void'($urandom(32'h39e9));
        for (int i = 0; i < 64; i++)
            dmem[i] = fill_word(32'(i) << 2);
        rnd    = $urandom;
        addr_a = {19'd0, rnd[4:0], 2'b00};         // Low half of the RAM
        addr_b = {18'd0, 1'b1, rnd[9:5], 2'b00};   // High half
        xa     = 5'd3 + {2'b00, rnd[12:10]};       // Four disjoint register ranges
        xb     = 5'd11 + {2'b00, rnd[15:13]};
        xc     = 5'd19 + {2'b00, rnd[18:16]};
        xd     = 5'd27 + {3'b000, rnd[20:19]};
        sh     = $urandom;
        set_reg(5'd1, addr_a);
        set_reg(5'd2, addr_b);
        rnd = $urandom;
        set_reg(xa, {1'b0, rnd[24:0]});   // Positive immediate
        store_to(5'd1, xa, "limm_pos");
        rnd = $urandom;
        set_reg(xb, {1'b1, rnd[24:0]});   // Negative immediate
        store_to(5'd1, xb, "limm_neg");
        op_store(zmips_pkg::alu_pass, xa, xb, xc, 5'd0, "alu_pass");
        op_store(zmips_pkg::alu_add, xa, xb, xc, 5'd0, "alu_add");
        op_store(zmips_pkg::alu_sub, xa, xb, xc, 5'd0, "alu_sub");
        op_store(zmips_pkg::alu_and, xa, xb, xc, 5'd0, "alu_and");
        op_store(zmips_pkg::alu_or, xa, xb, xc, 5'd0, "alu_or");
        op_store(zmips_pkg::alu_xor, xa, xb, xc, 5'd0, "alu_xor");
        op_store(zmips_pkg::alu_sll, xa, xb, xc, sh[4:0], "shift_sll");
        op_store(zmips_pkg::alu_srl, xb, xa, xc, sh[9:5], "shift_srl");
        op_store(zmips_pkg::alu_sra, xb, xa, xc, sh[14:10], "shift_sra_neg");
        op_store(zmips_pkg::alu_sra, xa, xb, xc, sh[19:15], "shift_sra_pos");
        emit(alu_word(zmips_pkg::alu_add, xa, xb, xc, 5'd0));
        emit(alu_word(zmips_pkg::alu_sub, xc, xb, xd, 5'd0));   // xc one back through MEM
        emit(alu_word(zmips_pkg::alu_xor, xc, xd, xd, 5'd0));   // xc two back through WB
        emit(alu_word(zmips_pkg::alu_or, xc, xd, xa, 5'd0));    // xc three back via RF bypass
        store_to(5'd1, xd, "fwd_chain_d");
        store_to(5'd1, xa, "fwd_chain_a");
        load_from(5'd2, xc);
        op_store(zmips_pkg::alu_add, xc, xb, xd, 5'd0, "load_use");   // Stalls one cycle
        load_from(5'd1, xc);
        store_to(5'd2, xc, "load_then_store");
        load_from(5'd2, xa);
        store_to(5'd1, xa, "reload");
        run_model();
        built = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        while (exp_addr.size() != 0)
            @(posedge clk);
        repeat (10) @(posedge clk);   // Room for a stray store to show
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- zmips.sv
// Top level: five-stage pipeline wiring with instruction and data memory ports
`timescale 1ns/1ps
`default_nettype none

module zmips (
    input  logic                       clk,
    input  logic                       rst,      // Synchronous, active high
    output logic [zmips_pkg::xlen-1:0] i_addr,
    input  logic [zmips_pkg::xlen-1:0] i_data,
    output logic [zmips_pkg::xlen-1:0] d_addr,
    output logic [zmips_pkg::xlen-1:0] d_wdata,
    input  logic [zmips_pkg::xlen-1:0] d_rdata,
    output logic                       d_wr,
    output logic                       d_rd
);

    zmips_pkg::instr_t            ir;           // IF/ID word
    logic                         stall;
    logic [zmips_pkg::reg_aw-1:0] rs;
    logic [zmips_pkg::reg_aw-1:0] rt;
    logic [1:0]                   rs_sel;
    logic [1:0]                   rt_sel;
    logic [zmips_pkg::xlen-1:0]   mem_rslt;
    // Write-back bus
    logic [zmips_pkg::xlen-1:0]   wb_data;
    logic [zmips_pkg::reg_aw-1:0] wb_reg;
    logic                         wb_wr;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    zmips_fetch fetch0 (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .i_data (i_data),
        .i_addr (i_addr),
        .ir     (ir)
    );

    zmips_decode decode0 (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .ir      (ir),
        .wb_reg  (wb_reg),
        .wb_data (wb_data),
        .wb_wr   (wb_wr),
        .rs      (rs),
        .rt      (rt),
        .id_ex   (id_ex.drv)
    );

    zmips_execute exec0 (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex.snk),
        .rs_sel   (rs_sel),
        .rt_sel   (rt_sel),
        .mem_rslt (mem_rslt),
        .wb_data  (wb_data),
        .ex_mem   (ex_mem.drv)
    );

    zmips_mem_wb memwb0 (
        .clk      (clk),
        .rst      (rst),
        .ex_mem   (ex_mem.snk),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .d_wr     (d_wr),
        .d_rd     (d_rd),
        .d_rdata  (d_rdata),
        .mem_rslt (mem_rslt),
        .wb_data  (wb_data),
        .wb_reg   (wb_reg),
        .wb_wr    (wb_wr)
    );

    zmips_hazard hazard0 (
        .rs     (rs),
        .rt     (rt),
        .id_ex  (id_ex.mon),
        .ex_mem (ex_mem.mon),
        .wb_reg (wb_reg),
        .wb_wr  (wb_wr),
        .stall  (stall),
        .rs_sel (rs_sel),
        .rt_sel (rt_sel)
    );

endmodule

`default_nettype wire

//--- zmips_alu.sv
// ALU: pass, add, subtract, logic operations and shifts by shamt
`timescale 1ns/1ps
`default_nettype none

module zmips_alu (
    input  logic [zmips_pkg::xlen-1:0]    a,
    input  logic [zmips_pkg::xlen-1:0]    b,
    input  logic [zmips_pkg::shamt_w-1:0] shamt,
    input  logic [3:0]                    op,
    output logic [zmips_pkg::xlen-1:0]    y
);

    always_comb
    begin
        case (op)
            zmips_pkg::alu_pass: y = a;         // Also load immediate
            zmips_pkg::alu_add:  y = a + b;
            zmips_pkg::alu_sub:  y = a - b;     // Plain two's complement
            zmips_pkg::alu_and:  y = a & b;
            zmips_pkg::alu_or:   y = a | b;
            zmips_pkg::alu_xor:  y = a ^ b;
            // Shifts act on a only
            zmips_pkg::alu_sll:  y = a << shamt;
            zmips_pkg::alu_srl:  y = a >> shamt;
            zmips_pkg::alu_sra:  y = $unsigned($signed(a) >>> shamt);
            default:             y = a;         // Reserved codes pass
        endcase
    end

endmodule

`default_nettype wire

//--- zmips_checker.sv
// Concurrent assertions on the zmips data port and fetch address
`timescale 1ns/1ps
`default_nettype none

module zmips_checker (
    input logic                       clk,
    input logic                       rst,
    input logic [zmips_pkg::xlen-1:0] i_addr,
    input logic                       d_wr,
    input logic                       d_rd
);

    // A single MEM stage never reads and writes at once
    no_rd_wr: assert property (@(posedge clk) disable iff (rst) !(d_wr && d_rd))
        else $error("d_wr and d_rd are high in the same cycle");

    // Data port stays quiet in reset and the cycle after
    quiet_rst: assert property (@(posedge clk) (rst || $past(rst)) |=> (!d_wr && !d_rd))
        else $error("data port active during or right after reset");

    // PC holds on a stall or steps one word
    pc_step: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (i_addr[1:0] == 2'b00 &&
                         (i_addr == $past(i_addr) || i_addr == $past(i_addr) + 32'd4)))
        else $error("i_addr misaligned or jumped");

endmodule

`default_nettype wire

//--- zmips_decode.sv
// Decode stage: field split, control generation, register file and ID/EX register
`timescale 1ns/1ps
`default_nettype none

module zmips_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  zmips_pkg::instr_t            ir,
    input  logic [zmips_pkg::reg_aw-1:0] wb_reg,
    input  logic [zmips_pkg::xlen-1:0]   wb_data,
    input  logic                         wb_wr,
    output logic [zmips_pkg::reg_aw-1:0] rs,     // To hazard unit
    output logic [zmips_pkg::reg_aw-1:0] rt,
    id_ex_if.drv                         id_ex
);

    logic [zmips_pkg::xlen-1:0] rs_val;
    logic [zmips_pkg::xlen-1:0] rt_val;
    logic [zmips_pkg::xlen-1:0] immd_se;
    logic [3:0]                 alu_op;
    logic                       rfmt;
    logic                       limm;
    logic                       mem_op;
    logic                       wr_op;

    assign rs = ir.r.rs;
    assign rt = ir.r.rt;

    // Format from the top op bits, anything else is a bubble
    assign rfmt = (ir.r.op[5:4] == zmips_pkg::fmt_rfmt);
    assign limm = (ir.r.op[5:4] == zmips_pkg::fmt_limm);

    assign mem_op = ir.r.op[zmips_pkg::op_mem_bit];
    assign wr_op  = ir.r.op[zmips_pkg::op_wrreg_bit];   // Also load vs store

    // 26-bit immediate seen through the I-format view
    assign immd_se = {{(zmips_pkg::xlen - 26){ir.i.immd[25]}}, ir.i.immd};

    // Load immediate just passes immd_se through
    assign alu_op = limm ? zmips_pkg::alu_pass
                         : {ir.r.op[zmips_pkg::op_shop_bit], ir.r.funct[5:3]};

    zmips_regfile rf0 (
        .clk     (clk),
        .rs      (ir.r.rs),
        .rt      (ir.r.rt),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .wb_reg  (wb_reg),
        .wb_data (wb_data),
        .wb_wr   (wb_wr)
    );

    always_ff @(posedge clk)
    begin
        id_ex.a_val   <= rs_val;
        id_ex.b_val   <= rt_val;
        id_ex.rs      <= ir.r.rs;
        id_ex.rt      <= ir.r.rt;
        id_ex.rd      <= limm ? '0 : ir.r.rd;   // Load immediate targets register 0
        id_ex.immd_se <= immd_se;
        id_ex.alu_op  <= alu_op;
        if (rst || stall || !(rfmt || limm))
        begin
            id_ex.alusrc <= 1'b0;   // Bubble
            id_ex.memrd  <= 1'b0;
            id_ex.memwr  <= 1'b0;
            id_ex.wrreg  <= 1'b0;
        end
        else
        begin
            id_ex.alusrc <= limm;
            id_ex.memrd  <= mem_op & wr_op;
            id_ex.memwr  <= mem_op & ~wr_op;
            id_ex.wrreg  <= wr_op;
        end
    end

endmodule

`default_nettype wire

//--- zmips_execute.sv
// Execute stage: forward muxes, immediate select, ALU and EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module zmips_execute (
    input  logic                       clk,
    input  logic                       rst,
    id_ex_if.snk                       id_ex,
    input  logic [1:0]                 rs_sel,
    input  logic [1:0]                 rt_sel,
    input  logic [zmips_pkg::xlen-1:0] mem_rslt,   // Load data or ALU result in MEM
    input  logic [zmips_pkg::xlen-1:0] wb_data,
    ex_mem_if.drv                      ex_mem
);

    logic [zmips_pkg::xlen-1:0] a_fwd;
    logic [zmips_pkg::xlen-1:0] b_fwd;
    logic [zmips_pkg::xlen-1:0] alu_a;
    logic [zmips_pkg::xlen-1:0] alu_y;

    // Same choice for both operands
    function automatic logic [zmips_pkg::xlen-1:0] fwd_pick(
        input logic [1:0]                 sel,
        input logic [zmips_pkg::xlen-1:0] reg_val,
        input logic [zmips_pkg::xlen-1:0] wb_val,
        input logic [zmips_pkg::xlen-1:0] mem_val
    );
        case (sel)
            zmips_pkg::fwd_wb:  return wb_val;
            zmips_pkg::fwd_mem: return mem_val;
            default:            return reg_val;
        endcase
    endfunction

    assign a_fwd = fwd_pick(rs_sel, id_ex.a_val, wb_data, mem_rslt);
    assign b_fwd = fwd_pick(rt_sel, id_ex.b_val, wb_data, mem_rslt);
    assign alu_a = id_ex.alusrc ? id_ex.immd_se : a_fwd;   // Load immediate

    zmips_alu alu0 (
        .a     (alu_a),
        .b     (b_fwd),
        .shamt (id_ex.immd_se[zmips_pkg::shamt_lsb +: zmips_pkg::shamt_w]),
        .op    (id_ex.alu_op),
        .y     (alu_y)
    );

    always_ff @(posedge clk)
    begin
        ex_mem.alu_rslt <= alu_y;
        ex_mem.st_data  <= b_fwd;       // Store data is forwarded rt
        ex_mem.wb_reg   <= id_ex.rd;
        if (rst)
        begin
            ex_mem.memrd <= 1'b0;
            ex_mem.memwr <= 1'b0;
            ex_mem.wrreg <= 1'b0;
        end
        else
        begin
            ex_mem.memrd <= id_ex.memrd;
            ex_mem.memwr <= id_ex.memwr;
            ex_mem.wrreg <= id_ex.wrreg;
        end
    end

endmodule

`default_nettype wire

//--- zmips_fetch.sv
// Fetch stage: program counter, incrementer and IF/ID instruction register
`timescale 1ns/1ps
`default_nettype none

module zmips_fetch (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,   // Load-use hold
    input  logic [zmips_pkg::xlen-1:0] i_data,
    output logic [zmips_pkg::xlen-1:0] i_addr,
    output zmips_pkg::instr_t          ir
);

    logic [zmips_pkg::xlen-1:0] pc;

    assign i_addr = pc;     // Instruction memory reads this cycle

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= '0;
            ir <= '0;       // Zero word decodes as a NOP
        end
        else if (!stall)
        begin
            pc <= pc + zmips_pkg::xlen'(zmips_pkg::pc_step);
            ir <= i_data;
        end
    end

endmodule

`default_nettype wire

//--- zmips_hazard.sv
// Hazard unit: load-use stall and EX operand forward selects
`timescale 1ns/1ps
`default_nettype none

module zmips_hazard (
    input  logic [zmips_pkg::reg_aw-1:0] rs,    // Sources of the instruction in ID
    input  logic [zmips_pkg::reg_aw-1:0] rt,
    id_ex_if.mon                         id_ex,
    ex_mem_if.mon                        ex_mem,
    input  logic [zmips_pkg::reg_aw-1:0] wb_reg,
    input  logic                         wb_wr,
    output logic                         stall,
    output logic [1:0]                   rs_sel,
    output logic [1:0]                   rt_sel
);

    // MEM beats WB, each only when that stage writes the register
    function automatic logic [1:0] fwd_sel(
        input logic [zmips_pkg::reg_aw-1:0] src,
        input logic [zmips_pkg::reg_aw-1:0] mem_reg,
        input logic                         mem_wr,
        input logic [zmips_pkg::reg_aw-1:0] wbk_reg,
        input logic                         wbk_wr
    );
        if (mem_wr && mem_reg == src)
        begin
            return zmips_pkg::fwd_mem;
        end
        else if (wbk_wr && wbk_reg == src)
        begin
            return zmips_pkg::fwd_wb;
        end
        return zmips_pkg::fwd_reg;
    endfunction

    // Load in EX feeds ID, hold one cycle
    assign stall = id_ex.memrd && (id_ex.rd == rs || id_ex.rd == rt);

    assign rs_sel = fwd_sel(id_ex.rs, ex_mem.wb_reg, ex_mem.wrreg, wb_reg, wb_wr);
    assign rt_sel = fwd_sel(id_ex.rt, ex_mem.wb_reg, ex_mem.wrreg, wb_reg, wb_wr);

endmodule

`default_nettype wire

//--- zmips_if.sv
// ID/EX and EX/MEM pipeline bundles with driver, sink and monitor modports
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if;
    logic [zmips_pkg::xlen-1:0]   a_val;     // Register file rs value
    logic [zmips_pkg::xlen-1:0]   b_val;     // Register file rt value
    logic [zmips_pkg::reg_aw-1:0] rs;
    logic [zmips_pkg::reg_aw-1:0] rt;
    logic [zmips_pkg::reg_aw-1:0] rd;        // Zero on load immediate
    logic [zmips_pkg::xlen-1:0]   immd_se;
    logic [3:0]                   alu_op;
    logic                         alusrc;    // ALU a from immd_se
    logic                         memrd;
    logic                         memwr;
    logic                         wrreg;

    modport drv (output a_val, b_val, rs, rt, rd, immd_se, alu_op, alusrc, memrd, memwr, wrreg);
    modport snk (input a_val, b_val, rs, rt, rd, immd_se, alu_op, alusrc, memrd, memwr, wrreg);
    modport mon (input rs, rt, rd, memrd);   // Load-use and forward checks
endinterface

interface ex_mem_if;
    logic [zmips_pkg::xlen-1:0]   alu_rslt;  // Also the data address
    logic [zmips_pkg::xlen-1:0]   st_data;   // Forwarded rt
    logic [zmips_pkg::reg_aw-1:0] wb_reg;
    logic                         memrd;
    logic                         memwr;
    logic                         wrreg;

    modport drv (output alu_rslt, st_data, wb_reg, memrd, memwr, wrreg);
    modport snk (input alu_rslt, st_data, wb_reg, memrd, memwr, wrreg);
    modport mon (input wb_reg, wrreg);
endinterface

`default_nettype wire

//--- zmips_mem_wb.sv
// Memory and write-back stages: data port, MEM/WB register and write-back select
`timescale 1ns/1ps
`default_nettype none

module zmips_mem_wb (
    input  logic                         clk,
    input  logic                         rst,
    ex_mem_if.snk                        ex_mem,
    output logic [zmips_pkg::xlen-1:0]   d_addr,
    output logic [zmips_pkg::xlen-1:0]   d_wdata,
    output logic                         d_wr,
    output logic                         d_rd,
    input  logic [zmips_pkg::xlen-1:0]   d_rdata,
    output logic [zmips_pkg::xlen-1:0]   mem_rslt,
    output logic [zmips_pkg::xlen-1:0]   wb_data,
    output logic [zmips_pkg::reg_aw-1:0] wb_reg,
    output logic                         wb_wr
);

    logic [zmips_pkg::xlen-1:0] memd_q;     // Load data
    logic [zmips_pkg::xlen-1:0] alud_q;     // ALU result
    logic                       memrd_q;

    // Data memory answers in the same cycle
    assign d_addr  = ex_mem.alu_rslt;
    assign d_wdata = ex_mem.st_data;
    assign d_wr    = ex_mem.memwr;
    assign d_rd    = ex_mem.memrd;

    assign mem_rslt = ex_mem.memrd ? d_rdata : ex_mem.alu_rslt;   // Forward to EX

    always_ff @(posedge clk)
    begin
        memd_q <= d_rdata;
        alud_q <= ex_mem.alu_rslt;
        wb_reg <= ex_mem.wb_reg;
        if (rst)
        begin
            memrd_q <= 1'b0;
            wb_wr   <= 1'b0;
        end
        else
        begin
            memrd_q <= ex_mem.memrd;
            wb_wr   <= ex_mem.wrreg;
        end
    end

    assign wb_data = memrd_q ? memd_q : alud_q;

endmodule

`default_nettype wire

//--- zmips_pkg.sv
// Widths, opcode bit positions, ALU codes, forward selects and the instruction word union
`default_nettype none

package zmips_pkg;

    // Widths and counts
    localparam int xlen     = 32;   // Data and address width
    localparam int reg_aw   = 5;    // Register address width
    localparam int num_regs = 32;
    localparam int pc_step  = 4;    // One word per instruction
    localparam int shamt_w  = 5;
    localparam int shamt_lsb = 6;   // Shamt position inside immd_se

    // Bit indices inside the 6-bit R-format op
    localparam int op_shop_bit  = 0;    // Shift operation
    localparam int op_wrreg_bit = 2;    // Write back to rd, also load (1) / store (0)
    localparam int op_mem_bit   = 3;    // Memory access

    // Top two op bits pick the format
    localparam logic [1:0] fmt_rfmt = 2'b00;
    localparam logic [1:0] fmt_limm = 2'b01;    // Low op bits are 0101

    // ALU codes, {shop, funct[5:3]}
    localparam logic [3:0] alu_pass = 4'b0_000;
    localparam logic [3:0] alu_add  = 4'b0_001;
    localparam logic [3:0] alu_sub  = 4'b0_010;
    localparam logic [3:0] alu_and  = 4'b0_011;
    localparam logic [3:0] alu_or   = 4'b0_100;
    localparam logic [3:0] alu_xor  = 4'b0_101;
    localparam logic [3:0] alu_sll  = 4'b1_000;
    localparam logic [3:0] alu_srl  = 4'b1_001;
    localparam logic [3:0] alu_sra  = 4'b1_010;

    // Operand forward selects
    localparam logic [1:0] fwd_reg = 2'b00;    // Register file value
    localparam logic [1:0] fwd_wb  = 2'b01;    // Write-back data
    localparam logic [1:0] fwd_mem = 2'b10;    // MEM stage result

    // One instruction word, seen as R-format or as I-format
    typedef union packed {
        struct packed {
            logic [5:0]        op;
            logic [reg_aw-1:0] rs;
            logic [reg_aw-1:0] rt;
            logic [reg_aw-1:0] rd;
            logic [4:0]        shamt;
            logic [5:0]        funct;   // Bits 5..3 pick the ALU operation
        } r;
        struct packed {
            logic [3:0]  op;
            logic [1:0]  cc;
            logic [25:0] immd;  // Sign-extended into register 0
        } i;
    } instr_t;

endpackage

`default_nettype wire

//--- zmips_regfile.sv
// Register file: 32 words, two combinational read ports, one write port with bypass
`timescale 1ns/1ps
`default_nettype none

module zmips_regfile (
    input  logic                         clk,
    input  logic [zmips_pkg::reg_aw-1:0] rs,
    input  logic [zmips_pkg::reg_aw-1:0] rt,
    output logic [zmips_pkg::xlen-1:0]   rs_val,
    output logic [zmips_pkg::xlen-1:0]   rt_val,
    input  logic [zmips_pkg::reg_aw-1:0] wb_reg,
    input  logic [zmips_pkg::xlen-1:0]   wb_data,
    input  logic                         wb_wr
);

    logic [zmips_pkg::xlen-1:0] regs [zmips_pkg::num_regs];

    always_ff @(posedge clk)
    begin
        if (wb_wr)
        begin
            regs[wb_reg] <= wb_data;
        end
    end

    // A write in this cycle is seen by the reader at once
    assign rs_val = (wb_wr && wb_reg == rs) ? wb_data : regs[rs];
    assign rt_val = (wb_wr && wb_reg == rt) ? wb_data : regs[rt];

endmodule

`default_nettype wire
